// ==== bubbleInterface.f ====
verilog/bubbleGeometryPkg.sv
verilog/bubbleBusPkg.sv
verilog/bubbleLoaderPort.sv
verilog/bubbleChannelBuffer.sv
verilog/bubbleAccessControl.sv
verilog/bubblePageSequencer.sv
verilog/bubbleInterface.sv
dv/bubbleInterface_assertions.sv
dv/bubbleInterfaceChecker.sv
dv/bubbleInterfaceTb.sv

// ==== dv/bubbleInterfaceChecker.sv ====
`timescale 1ns/1ns

module bubbleInterfaceChecker
#(
    parameter int TotalPositions = 2053,
    parameter int PageLeadTicks  = 100,
    parameter int PageWords      = 512
)
(
    input  logic                            bubble_buffer_write_clock,
    input  logic                            reset,
    input  bubbleBusPkg::wbRequest_t        wbRequest,
    input  logic                            coilRun,
    input  logic                            positionConvert,
    input  logic                            positionTick,
    input  logic                            dataOutputTick,
    input  bubbleBusPkg::wbResponse_t       wbResponse,
    input  logic                            loadPage,
    input  bubbleGeometryPkg::position_t    currentPosition,
    input  logic                            bubbleOutOdd,
    input  logic                            bubbleOutEven,
    output int                              errorCount
);

    import bubbleGeometryPkg::*;

    channelBits_t wordModel [0:(1 << BufferAddrWidth)-1];      // Page buffer as the bus left it
    channelBits_t fetchedModel;                                 // Word picked up on a fetch slot
    accessState_t stateModel;
    logic         loadPageModel;
    logic         ackModel;
    position_t    positionModel;
    logic         oddModel;
    logic         evenModel;
    int           tickModel;                                    // Ticks since loadPage rose
    logic         modelValid = 1'b0;                            // Set by the first reset

    initial errorCount = 0;

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] observed);
        if (observed !== expected)
        begin
            $display("Error at %0t ns: %s expected %0h observed %0h", $time, name,
                     expected, observed);
            errorCount++;
        end
    endtask

    // Negedge sees settled outputs and the inputs of the coming edge
    always @(negedge bubble_buffer_write_clock)
    begin
        int           offset;
        logic         requestNew;
        if (modelValid)
        begin
            compareValue("wbResponse.ack", 32'(ackModel), 32'(wbResponse.ack));
            compareValue("loadPage", 32'(loadPageModel), 32'(loadPage));
            compareValue("currentPosition", 32'(positionModel), 32'(currentPosition));
            compareValue("bubbleOutOdd", 32'(oddModel), 32'(bubbleOutOdd));
            compareValue("bubbleOutEven", 32'(evenModel), 32'(bubbleOutEven));
        end
        // Slot rules, driven by the page flag already registered
        if (!loadPageModel)
        begin
            oddModel  = 1'b1;
            evenModel = 1'b1;
            tickModel = 0;                                      // Held between pages
        end
        else if (dataOutputTick)
        begin
            offset = tickModel - PageLeadTicks;
            if (tickModel >= PageLeadTicks && offset < 2 * PageWords)
            begin
                if (offset % 2 == 0)
                    fetchedModel = wordModel[bufferAddr_t'(offset / 2)]; // Fetch, outputs hold
                else
                begin
                    oddModel  = ~fetchedModel[1];               // Word k inverted
                    evenModel = ~fetchedModel[0];
                end
            end
            else
            begin
                oddModel  = 1'b1;                               // Lead-in or trailing slot
                evenModel = 1'b1;
            end
            tickModel++;
        end
        // Bus write after the fetch, so a same-edge read keeps the old word
        requestNew = wbRequest.cyc & wbRequest.stb & ~ackModel;
        if (requestNew && wbRequest.we)
            wordModel[wbRequest.adr] = wbRequest.datWrite;
        ackModel = requestNew;
        // Access state, coil stop first
        if (!coilRun)
            stateModel = Idle;
        else
        begin
            case (stateModel)
                Idle:    stateModel = Armed;
                Armed:   if (positionConvert) stateModel = LoadPage;
                default: stateModel = stateModel;              // LoadPage ignores convert
            endcase
        end
        loadPageModel = (stateModel == LoadPage);
        if (positionTick)
            positionModel = (positionModel == position_t'(TotalPositions - 1)) ? '0
                            : positionModel + 1'b1;
        if (reset)
        begin
            stateModel    = Idle;
            loadPageModel = 1'b0;
            ackModel      = 1'b0;
            positionModel = '0;
            oddModel      = 1'b1;
            evenModel     = 1'b1;
            tickModel     = 0;
            modelValid    = 1'b1;
        end
    end

endmodule

// ==== dv/bubbleInterfaceTb.sv ====
`timescale 1ns/1ns

module bubbleInterfaceTb;

    import bubbleGeometryPkg::*;
    import bubbleBusPkg::*;

    localparam int TotalPositions = 2053;
    localparam int PageLeadTicks  = 100;
    localparam int PageWords      = 512;
    localparam int NumPages       = 4;
    localparam int ReloadWords    = 64;                         // Rewritten between pages
    localparam int FullPageTicks  = PageLeadTicks + 2 * PageWords + 10; // Reaches trailing slots
    localparam int LoadCycles     = (PageWords + NumPages * ReloadWords) * 8 + 400;
    localparam longint TimeLimit  =
        longint'((NumPages * (PageLeadTicks + 2 * PageWords + 20) * 5 + LoadCycles) * 8);

    logic         bubble_buffer_write_clock;
    logic         reset;
    wbRequest_t   wbRequest;
    logic         coilRun;
    logic         positionConvert;
    logic         positionTick;
    logic         dataOutputTick;
    wbResponse_t  wbResponse;
    logic         loadPage;
    position_t    currentPosition;
    logic         bubbleOutOdd;
    logic         bubbleOutEven;
    int           checkErrors;
    int           busErrors;
    logic [31:0]  lfsrState;

    bubbleInterface DUT
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .reset                     (reset),
        .wbRequest                 (wbRequest),
        .coilRun                   (coilRun),
        .positionConvert           (positionConvert),
        .positionTick              (positionTick),
        .dataOutputTick            (dataOutputTick),
        .wbResponse                (wbResponse),
        .loadPage                  (loadPage),
        .currentPosition           (currentPosition),
        .bubbleOutOdd              (bubbleOutOdd),
        .bubbleOutEven             (bubbleOutEven)
    );

    bubbleInterfaceChecker
    #(
        .TotalPositions (TotalPositions),
        .PageLeadTicks  (PageLeadTicks),
        .PageWords      (PageWords)
    )
    uChecker
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .reset                     (reset),
        .wbRequest                 (wbRequest),
        .coilRun                   (coilRun),
        .positionConvert           (positionConvert),
        .positionTick              (positionTick),
        .dataOutputTick            (dataOutputTick),
        .wbResponse                (wbResponse),
        .loadPage                  (loadPage),
        .currentPosition           (currentPosition),
        .bubbleOutOdd              (bubbleOutOdd),
        .bubbleOutEven             (bubbleOutEven),
        .errorCount                (checkErrors)
    );

    // Galois LFSR over x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return value;
    endfunction

    task automatic nextCycle(input int count);
        repeat (count)
        begin
            @(posedge bubble_buffer_write_clock);
            #1;                                                 // Drive just after the edge
        end
    endtask

    // Counts tick strobes as the DUT will sample them
    task automatic countTicks(input int count);
        int seen;
        seen = 0;
        while (seen < count)
        begin
            @(negedge bubble_buffer_write_clock);
            if (dataOutputTick)
                seen++;
            nextCycle(1);
        end
    endtask

    task automatic busCycle(input logic writeCycle, input bufferAddr_t address,
                            input channelBits_t bits);
        int waited;
        wbRequest.cyc      = 1'b1;
        wbRequest.stb      = 1'b1;
        wbRequest.we       = writeCycle;
        wbRequest.adr      = address;
        wbRequest.datWrite = bits;
        waited = 0;
        do
        begin
            nextCycle(1);
            waited++;
        end
        while (!wbResponse.ack && waited < 16);                 // Held until ack
        if (!wbResponse.ack)
        begin
            $display("Bus cycle to word %0d was never acknowledged", address);
            busErrors++;
        end
        wbRequest = '0;
    endtask

    initial
    begin
        bubble_buffer_write_clock = 1'b0;
        forever #4 bubble_buffer_write_clock = ~bubble_buffer_write_clock;
    end

    // Strobe levels drawn at the falling edge and applied after the next rising edge
    initial
    begin : strobeDriver
        int   gapLeft;
        logic tickNext;
        logic strobeNext;
        gapLeft = 3;
        @(negedge reset);
        forever
        begin
            @(negedge bubble_buffer_write_clock);
            tickNext = (randomBits(1) == 32'd1);                // About every other cycle
            if (gapLeft == 0)
            begin
                strobeNext = 1'b1;
                gapLeft    = 1 + int'(randomBits(2));           // Next strobe 2 to 5 cycles on
            end
            else
            begin
                strobeNext = 1'b0;
                gapLeft--;
            end
            nextCycle(1);
            positionTick   = tickNext;
            dataOutputTick = strobeNext;
        end
    end

    initial
    begin : mainSequence
        int          stride;
        int          start;
        int          pageTicks;
        bufferAddr_t address;
        channelBits_t bits;
        lfsrState       = 32'hcfbb9bd9;
        reset           = 1'b1;
        wbRequest       = '0;
        coilRun         = 1'b0;
        positionConvert = 1'b0;
        positionTick    = 1'b0;
        dataOutputTick  = 1'b0;
        busErrors       = 0;
        repeat (16) @(posedge bubble_buffer_write_clock);
        #1;
        reset = 1'b0;
        // Whole page in a shuffled order
        stride = 2 * int'(randomBits(8)) + 1;                   // Odd stride visits every word once
        start  = int'(randomBits(9));
        for (int k = 0; k < PageWords; k++)
        begin
            address = bufferAddr_t'((start + k * stride) % PageWords);
            bits    = channelBits_t'(randomBits(2));
            busCycle(1'b1, address, bits);
            if (randomBits(3) == 32'd0)
                busCycle(1'b0, address, ~bits);                 // Read cycle must leave the word
        end
        positionConvert = 1'b1;                                 // Ignored in Idle
        nextCycle(1);
        coilRun = 1'b1;                                         // Convert with coil start
        nextCycle(1);
        coilRun = 1'b0;                                         // Coil stop beats convert
        nextCycle(1);
        positionConvert = 1'b0;
        nextCycle(2);
        for (int page = 0; page < NumPages; page++)
        begin
            coilRun = 1'b1;
            nextCycle(2 + int'(randomBits(3)));                 // Armed for a while
            positionConvert = 1'b1;
            nextCycle(1);
            positionConvert = 1'b0;
            if (page == 1)
                pageTicks = PageLeadTicks + int'(randomBits(10)); // Cut off in the data
            else
                pageTicks = FullPageTicks;
            countTicks(200);
            positionConvert = 1'b1;                             // Ignored during a page
            nextCycle(1);
            positionConvert = 1'b0;
            countTicks(pageTicks - 200);
            coilRun = 1'b0;
            nextCycle(4 + int'(randomBits(2)));
            for (int w = 0; w < ReloadWords; w++)
                busCycle(1'b1, bufferAddr_t'(randomBits(9)), channelBits_t'(randomBits(2)));
        end
        nextCycle(10);
        $display("Errors: %0d checker, %0d bus, %0d assertion", checkErrors, busErrors,
                 DUT.uAssertions.violationCount);
        if (checkErrors == 0 && busErrors == 0 && DUT.uAssertions.violationCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin : watchdog
        #(TimeLimit);
        $display("Run timed out after %0d ns before the last page was sent", TimeLimit);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== dv/bubbleInterface_assertions.sv ====
`timescale 1ns/1ns

module bubbleInterfaceAssertions
(
    input logic                         bubble_buffer_write_clock,
    input logic                         reset,
    input bubbleBusPkg::wbResponse_t    wbResponse,
    input logic                         coilRun,
    input logic                         loadPage,
    input logic                         bubbleOutOdd,
    input logic                         bubbleOutEven
);

    int violationCount = 0;                                     // Read by the testbench top

    ackSinglePulse: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        wbResponse.ack |=> !wbResponse.ack)
    else
    begin
        $error("Wishbone ack stayed high for two cycles");
        violationCount++;
    end

    idleWithoutPage: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        !loadPage |=> (bubbleOutOdd && bubbleOutEven))
    else
    begin
        $error("Bubble outputs not idle high outside a page");
        violationCount++;
    end

    noPageAfterCoilStop: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        !coilRun |=> !$rose(loadPage))
    else
    begin
        $error("loadPage rose right after coilRun was low");
        violationCount++;
    end

endmodule

// Attached to every instance of the top level
bind bubbleInterface bubbleInterfaceAssertions uAssertions
(
    .bubble_buffer_write_clock (bubble_buffer_write_clock),
    .reset                     (reset),
    .wbResponse                (wbResponse),
    .coilRun                   (coilRun),
    .loadPage                  (loadPage),
    .bubbleOutOdd              (bubbleOutOdd),
    .bubbleOutEven             (bubbleOutEven)
);

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module bubbleInterfaceTb \
    -f bubbleInterface.f

output=$(./obj_dir/VbubbleInterfaceTb +verilator+error+limit+100)
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== verilog/bubbleAccessControl.sv ====
`timescale 1ns/1ns

module bubbleAccessControl
#(
    parameter int TotalPositions = 2053                         // Positions per loop
)
(
    input  logic                            bubble_buffer_write_clock,
    input  logic                            reset,
    input  logic                            coilRun,
    input  logic                            positionConvert,
    input  logic                            positionTick,
    output logic                            loadPage,
    output bubbleGeometryPkg::position_t    currentPosition
);

    import bubbleGeometryPkg::*;

    localparam position_t LastPosition = position_t'(TotalPositions - 1); // Wrap point

    accessState_t state;
    accessState_t stateNext;

    always_comb
    begin
        stateNext = state;                                      // Hold by default
        case (state)
            Idle:      if (coilRun) stateNext = Armed;          // Convert ignored here
            Armed:     if (positionConvert) stateNext = LoadPage;
            LoadPage:  stateNext = LoadPage;                    // Stays until coils stop
            default:   stateNext = Idle;
        endcase
        if (!coilRun)
        begin
            stateNext = Idle;                                   // Coil stop beats convert
        end
    end

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset)
        begin
            state    <= Idle;
            loadPage <= 1'b0;
        end
        else
        begin
            state    <= stateNext;
            loadPage <= (stateNext == LoadPage);                // High exactly in LoadPage
        end
    end

    // Position counter, free running with the coil field
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset)
        begin
            currentPosition <= '0;                              // Only reset clears it
        end
        else if (positionTick)
        begin
            if (currentPosition == LastPosition)
            begin
                currentPosition <= '0;                          // Wrap to 0
            end
            else
            begin
                currentPosition <= currentPosition + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/bubbleBusPkg.sv ====
package bubbleBusPkg;

    // Wishbone classic, master to slave
    typedef struct packed
    {
        logic cyc;                                              // Bus cycle in progress
        logic stb;                                              // Transfer strobe
        logic we;                                               // High for write
        bubbleGeometryPkg::bufferAddr_t adr;                    // Buffer word address
        bubbleGeometryPkg::channelBits_t datWrite;              // Odd and even bits
    } wbRequest_t;

    // Wishbone classic, slave to master
    typedef struct packed
    {
        logic ack;                                              // Single cycle acknowledge
    } wbResponse_t;

    // Write broadcast to every channel buffer
    typedef struct packed
    {
        logic enable;                                           // One cycle write strobe
        bubbleGeometryPkg::bufferAddr_t address;                // Word to write
        bubbleGeometryPkg::channelBits_t bits;                  // Each buffer keeps its own bit
    } bufferWrite_t;

    // Write only port, reads come back with ack and no data

endpackage

// ==== verilog/bubbleChannelBuffer.sv ====
`timescale 1ns/1ns

module bubbleChannelBuffer
#(
    parameter int Channel = 0                                   // Bit of the word kept here
)
(
    input  logic                            bubble_buffer_write_clock,
    input  bubbleBusPkg::bufferWrite_t      bufferWrite,
    input  logic                            readEnable,
    input  bubbleGeometryPkg::bufferAddr_t  readAddress,
    output logic                            readBit
);

    import bubbleGeometryPkg::*;

    localparam int Depth = 1 << BufferAddrWidth;                // One bit per page word

    logic bitPlane [0:Depth-1];                                 // Block RAM bit plane

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (bufferWrite.enable)
        begin
            bitPlane[bufferWrite.address] <= bufferWrite.bits[Channel]; // Own channel only
        end
    end

    // Registered read, returns old bit on a same-address write
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (readEnable)
        begin
            readBit <= bitPlane[readAddress];                   // Held until next fetch
        end
    end

endmodule

// ==== verilog/bubbleGeometryPkg.sv ====
package bubbleGeometryPkg;

    // Page buffer geometry
    localparam int BufferAddrWidth = 11;                       // 2048 words per buffer
    typedef logic [BufferAddrWidth-1:0] bufferAddr_t;           // Word address

    // One bit per bubble channel
    localparam int NumChannelsDefault = 2;                      // Odd and even channel
    typedef logic [NumChannelsDefault-1:0] channelBits_t;       // Bit 1 odd, bit 0 even

    // Bubble position as seen by the page converter
    localparam int PositionWidth = 12;                          // Covers 2053 positions
    typedef logic [PositionWidth-1:0] position_t;

    // Data output ticks since the page started
    localparam int TickCountWidth = 14;                         // Saturates at all ones
    typedef logic [TickCountWidth-1:0] tickCount_t;

    // Access controller states
    typedef enum logic [1:0]
    {
        Idle,                                                   // Coils stopped
        Armed,                                                  // Coils running, no page yet
        LoadPage                                                // Page being shifted out
    } accessState_t;

endpackage

// ==== verilog/bubbleInterface.sv ====
`timescale 1ns/1ns

module bubbleInterface
#(
    parameter int NumChannels    = 2,                           // Odd and even
    parameter int TotalPositions = 2053,                        // Positions 0 to 2052
    parameter int PageLeadTicks  = 100,                         // Idle ticks before data
    parameter int PageWords      = 512                          // Words per page
)
(
    input  logic                            bubble_buffer_write_clock,
    input  logic                            reset,
    input  bubbleBusPkg::wbRequest_t        wbRequest,
    input  logic                            coilRun,
    input  logic                            positionConvert,
    input  logic                            positionTick,
    input  logic                            dataOutputTick,
    output bubbleBusPkg::wbResponse_t       wbResponse,
    output logic                            loadPage,
    output bubbleGeometryPkg::position_t    currentPosition,
    output logic                            bubbleOutOdd,
    output logic                            bubbleOutEven
);

    import bubbleGeometryPkg::*;
    import bubbleBusPkg::*;

    bufferWrite_t bufferWrite;                                  // Loader to every channel
    logic         readEnable;                                   // Sequencer fetch strobe
    bufferAddr_t  readAddress;                                  // Word being fetched
    channelBits_t channelBits;                                  // Gathered channel read bits

    bubbleLoaderPort uLoaderPort
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .reset                     (reset),
        .wbRequest                 (wbRequest),
        .wbResponse                (wbResponse),
        .bufferWrite               (bufferWrite)
    );

    // One bit plane per bubble channel
    for (genvar ch = 0; ch < NumChannels; ch++)
    begin : gChannel
        bubbleChannelBuffer #(.Channel(ch)) uChannelBuffer
        (
            .bubble_buffer_write_clock (bubble_buffer_write_clock),
            .bufferWrite               (bufferWrite),
            .readEnable                (readEnable),
            .readAddress               (readAddress),
            .readBit                   (channelBits[ch])
        );
    end

    bubbleAccessControl #(.TotalPositions(TotalPositions)) uAccessControl
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .reset                     (reset),
        .coilRun                   (coilRun),
        .positionConvert           (positionConvert),
        .positionTick              (positionTick),
        .loadPage                  (loadPage),
        .currentPosition           (currentPosition)
    );

    bubblePageSequencer
    #(
        .NumChannels   (NumChannels),
        .PageLeadTicks (PageLeadTicks),
        .PageWords     (PageWords)
    )
    uPageSequencer
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .reset                     (reset),
        .loadPage                  (loadPage),                  // Also a top level output
        .dataOutputTick            (dataOutputTick),
        .channelBits               (channelBits),
        .readEnable                (readEnable),
        .readAddress               (readAddress),
        .bubbleOutOdd              (bubbleOutOdd),
        .bubbleOutEven             (bubbleOutEven)
    );

endmodule

// ==== verilog/bubbleLoaderPort.sv ====
`timescale 1ns/1ns

module bubbleLoaderPort
(
    input  logic                        bubble_buffer_write_clock,
    input  logic                        reset,
    input  bubbleBusPkg::wbRequest_t    wbRequest,
    output bubbleBusPkg::wbResponse_t   wbResponse,
    output bubbleBusPkg::bufferWrite_t  bufferWrite
);

    logic requestSeen;                                          // New request, not yet acked
    logic ackReg;                                               // Registered ack

    // A request held through its ack cycle is not seen twice
    assign requestSeen = wbRequest.cyc & wbRequest.stb & ~ackReg;

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset)
        begin
            ackReg <= 1'b0;                                     // No ack out of reset
        end
        else
        begin
            ackReg <= requestSeen;                              // Ack one cycle after request
        end
    end

    assign wbResponse.ack = ackReg;

    // Write lands on the same edge that raises ack
    assign bufferWrite.enable  = requestSeen & wbRequest.we;    // Reads only get ack
    assign bufferWrite.address = wbRequest.adr;                 // Held by master until ack
    assign bufferWrite.bits    = wbRequest.datWrite;            // Both channels, split later

endmodule

// ==== verilog/bubblePageSequencer.sv ====
`timescale 1ns/1ns

module bubblePageSequencer
#(
    parameter int NumChannels   = 2,                            // Odd channel is the top one
    parameter int PageLeadTicks = 100,                          // Idle ticks before data
    parameter int PageWords     = 512                           // Words shifted per page
)
(
    input  logic                            bubble_buffer_write_clock,
    input  logic                            reset,
    input  logic                            loadPage,
    input  logic                            dataOutputTick,
    input  bubbleGeometryPkg::channelBits_t channelBits,
    output logic                            readEnable,
    output bubbleGeometryPkg::bufferAddr_t  readAddress,
    output logic                            bubbleOutOdd,
    output logic                            bubbleOutEven
);

    import bubbleGeometryPkg::*;

    localparam tickCount_t LeadTicks  = tickCount_t'(PageLeadTicks);
    localparam tickCount_t DataTicks  = tickCount_t'(2 * PageWords); // Fetch and output per word
    localparam tickCount_t LastTick   = '1;                     // Saturation value
    localparam int         OddChannel = NumChannels - 1;

    tickCount_t tickIndex;                                      // Ticks since loadPage rose
    tickCount_t dataIndex;                                      // Ticks since lead-in ended
    logic       inDataWindow;
    logic       fetchSlot;
    logic       outputSlot;
    logic       pageTick;

    assign pageTick = loadPage & dataOutputTick;

    // Slot decode
    assign dataIndex    = tickIndex - LeadTicks;                // Meaningless inside lead-in
    assign inDataWindow = (tickIndex >= LeadTicks) && (dataIndex < DataTicks);
    assign fetchSlot    = inDataWindow & ~dataIndex[0];         // Even offset fetches word k
    assign outputSlot   = inDataWindow & dataIndex[0];          // Odd offset shifts word k out

    // Read of word k on its fetch tick, bits ready next cycle
    assign readEnable  = pageTick & fetchSlot;
    assign readAddress = bufferAddr_t'(dataIndex >> 1);         // k = offset / 2

    // Tick counter
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset || !loadPage)
        begin
            tickIndex <= '0;                                    // Held at 0 between pages
        end
        else if (dataOutputTick && (tickIndex != LastTick))
        begin
            tickIndex <= tickIndex + 1'b1;                      // Never wraps within a page
        end
    end

    // Channel output drive
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset || !loadPage)
        begin
            bubbleOutOdd  <= 1'b1;                              // Idle high
            bubbleOutEven <= 1'b1;
        end
        else if (dataOutputTick)
        begin
            if (outputSlot)
            begin
                bubbleOutOdd  <= ~channelBits[OddChannel];      // Bubble present drives low
                bubbleOutEven <= ~channelBits[0];
            end
            else if (!fetchSlot)
            begin
                bubbleOutOdd  <= 1'b1;                          // Lead-in and trailing slots
                bubbleOutEven <= 1'b1;
            end
            // Fetch slots keep the previous word on the outputs
        end
    end

endmodule
